// File: hw/conv_pkg.sv
package conv_pkg;

	// data widths
	localparam int pix_w  = 8;
	localparam int tap_w  = 8;
	localparam int n_taps = 9;
	localparam int mem_w  = 32;
	localparam int addr_w = 32;
	localparam int dim_w  = 16;

	// nine products of u8 pixel and s8 tap, no overflow
	localparam int sum_w = 20;

	localparam int pix_max = (2 ** pix_w) - 1; // saturation ceiling

	// configuration block in external memory
	localparam logic [addr_w-1:0] config_addr = 32'h1000_0000;
	localparam int config_words = 13;

	// word offsets inside the configuration block
	localparam int cfg_width  = 0;
	localparam int cfg_height = 1;
	localparam int cfg_src    = 2;
	localparam int cfg_dst    = 3;
	localparam int cfg_tap0   = 4; // taps 0..8, row-major, tap 0 is top-left

	// compute strobe to result valid
	localparam int pipe_depth = 2;

endpackage

// File: hw/mem_requester.sv
module mem_requester (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cmd_valid,
	input  logic                          cmd_we,
	input  logic [conv_pkg::addr_w-1:0]   cmd_addr,
	input  logic [conv_pkg::mem_w-1:0]    cmd_wdata,
	input  logic                          mem_ack,
	input  logic [conv_pkg::mem_w-1:0]    mem_rdata,
	output logic                          busy,
	output logic                          rsp_valid,
	output logic [conv_pkg::mem_w-1:0]    rsp_rdata,
	output logic                          mem_req,
	output logic                          mem_we,
	output logic [conv_pkg::addr_w-1:0]   mem_addr,
	output logic [conv_pkg::mem_w-1:0]    mem_wdata
);

	typedef enum logic [1:0] {
		rq_idle,
		rq_wait_hi,
		rq_wait_lo,
		rq_resp
	} rq_state_t;

	rq_state_t state;
	logic      accept;

	assign busy      = (state == rq_wait_hi) || (state == rq_wait_lo);
	assign accept    = cmd_valid && !busy;
	assign mem_req   = (state == rq_wait_hi);
	assign rsp_valid = (state == rq_resp); // ack already back low here

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state  <= rq_idle;
			mem_we <= 1'b0;
		end else begin
			case (state)
				rq_idle, rq_resp: begin
					if (accept) begin
						state  <= rq_wait_hi;
						mem_we <= cmd_we;
					end else begin
						state <= rq_idle;
					end
				end
				rq_wait_hi: if (mem_ack) state <= rq_wait_lo;
				rq_wait_lo: if (!mem_ack) state <= rq_resp;
				default: state <= rq_idle;
			endcase
		end
	end

	// command held stable for the whole handshake
	always_ff @(posedge clk) begin
		if (accept) begin
			mem_addr  <= cmd_addr;
			mem_wdata <= cmd_wdata;
		end
		if (mem_req && mem_ack) begin
			rsp_rdata <= mem_rdata;
		end
	end

endmodule

// File: hw/conv_config_loader.sv
module conv_config_loader (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 load_start,
	input  logic                                 rsp_valid,
	input  logic [conv_pkg::mem_w-1:0]           rsp_rdata,
	input  logic                                 req_busy,
	output logic                                 ld_cmd_valid,
	output logic [conv_pkg::addr_w-1:0]          ld_cmd_addr,
	output logic                                 load_done,
	output logic [conv_pkg::dim_w-1:0]           image_width,
	output logic [conv_pkg::dim_w-1:0]           image_height,
	output logic [conv_pkg::addr_w-1:0]          src_addr,
	output logic [conv_pkg::addr_w-1:0]          dst_addr,
	output logic signed [conv_pkg::tap_w-1:0]    tap0,
	output logic signed [conv_pkg::tap_w-1:0]    tap1,
	output logic signed [conv_pkg::tap_w-1:0]    tap2,
	output logic signed [conv_pkg::tap_w-1:0]    tap3,
	output logic signed [conv_pkg::tap_w-1:0]    tap4,
	output logic signed [conv_pkg::tap_w-1:0]    tap5,
	output logic signed [conv_pkg::tap_w-1:0]    tap6,
	output logic signed [conv_pkg::tap_w-1:0]    tap7,
	output logic signed [conv_pkg::tap_w-1:0]    tap8
);

	typedef enum logic [1:0] {
		ld_idle,
		ld_issue,
		ld_wait
	} ld_state_t;

	ld_state_t state;
	logic [3:0] idx; // word offset being fetched
	logic       last;
	logic signed [conv_pkg::tap_w-1:0] taps [conv_pkg::n_taps];

	assign last         = (idx == 4'(conv_pkg::config_words - 1));
	assign ld_cmd_valid = (state == ld_issue) && !req_busy;
	assign ld_cmd_addr  = conv_pkg::config_addr + conv_pkg::addr_w'(idx);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state     <= ld_idle;
			idx       <= '0;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0;
			case (state)
				ld_idle: begin
					if (load_start) begin
						idx   <= '0;
						state <= ld_issue;
					end
				end
				ld_issue: if (!req_busy) state <= ld_wait;
				ld_wait: begin
					if (rsp_valid) begin
						if (last) begin
							load_done <= 1'b1;
							state     <= ld_idle;
						end else begin
							idx   <= idx + 4'd1;
							state <= ld_issue;
						end
					end
				end
				default: state <= ld_idle;
			endcase
		end
	end

	// steer each word by its offset
	always_ff @(posedge clk) begin
		if ((state == ld_wait) && rsp_valid) begin
			case (idx)
				4'(conv_pkg::cfg_width):  image_width  <= rsp_rdata[conv_pkg::dim_w-1:0];
				4'(conv_pkg::cfg_height): image_height <= rsp_rdata[conv_pkg::dim_w-1:0];
				4'(conv_pkg::cfg_src):    src_addr     <= rsp_rdata[conv_pkg::addr_w-1:0];
				4'(conv_pkg::cfg_dst):    dst_addr     <= rsp_rdata[conv_pkg::addr_w-1:0];
				default: taps[idx - 4'(conv_pkg::cfg_tap0)] <= rsp_rdata[conv_pkg::tap_w-1:0];
			endcase
		end
	end

	assign tap0 = taps[0];
	assign tap1 = taps[1];
	assign tap2 = taps[2];
	assign tap3 = taps[3];
	assign tap4 = taps[4];
	assign tap5 = taps[5];
	assign tap6 = taps[6];
	assign tap7 = taps[7];
	assign tap8 = taps[8];

endmodule

// File: hw/conv_controller.sv
module conv_controller (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 start,
	input  logic                                 busy_req,
	input  logic                                 rsp_valid,
	input  logic [conv_pkg::mem_w-1:0]           rsp_rdata,
	input  logic                                 res_valid,
	input  logic [conv_pkg::pix_w-1:0]           res_data,
	output logic                                 busy,
	output logic                                 done,
	output logic                                 cmd_valid,
	output logic                                 cmd_we,
	output logic [conv_pkg::addr_w-1:0]          cmd_addr,
	output logic [conv_pkg::mem_w-1:0]           cmd_wdata,
	output logic                                 pix_valid,
	output logic [1:0]                           pix_row,
	output logic [conv_pkg::pix_w-1:0]           pix_data,
	output logic                                 shift_cols,
	output logic                                 compute,
	output logic signed [conv_pkg::tap_w-1:0]    tap0,
	output logic signed [conv_pkg::tap_w-1:0]    tap1,
	output logic signed [conv_pkg::tap_w-1:0]    tap2,
	output logic signed [conv_pkg::tap_w-1:0]    tap3,
	output logic signed [conv_pkg::tap_w-1:0]    tap4,
	output logic signed [conv_pkg::tap_w-1:0]    tap5,
	output logic signed [conv_pkg::tap_w-1:0]    tap6,
	output logic signed [conv_pkg::tap_w-1:0]    tap7,
	output logic signed [conv_pkg::tap_w-1:0]    tap8
);

	typedef enum logic [3:0] {
		st_idle,
		st_config,
		st_read_pix,
		st_shift,
		st_compute,
		st_wait_res,
		st_write_res,
		st_next,
		st_finish
	} state_t;

	state_t state;
	logic load_start, ld_cmd_valid, load_done;
	logic issued; // own command in flight
	logic own_cmd, small_img, col_last, row_last;
	logic [conv_pkg::addr_w-1:0] ld_cmd_addr, src_addr, dst_addr, width_a;
	logic [conv_pkg::addr_w-1:0] row_base, col_base, pix_addr, res_addr;
	logic [conv_pkg::dim_w-1:0]  image_width, image_height, row, col;
	logic [1:0]                  pr;
	logic [conv_pkg::pix_w-1:0]  res_byte;

	conv_config_loader loader0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.load_start   (load_start),
		.rsp_valid    (rsp_valid),
		.rsp_rdata    (rsp_rdata),
		.req_busy     (busy_req),
		.ld_cmd_valid (ld_cmd_valid),
		.ld_cmd_addr  (ld_cmd_addr),
		.load_done    (load_done),
		.image_width  (image_width),
		.image_height (image_height),
		.src_addr     (src_addr),
		.dst_addr     (dst_addr),
		.tap0         (tap0),
		.tap1         (tap1),
		.tap2         (tap2),
		.tap3         (tap3),
		.tap4         (tap4),
		.tap5         (tap5),
		.tap6         (tap6),
		.tap7         (tap7),
		.tap8         (tap8)
	);

	assign busy       = !((state == st_idle) || (state == st_finish));
	assign done       = (state == st_finish);
	assign load_start = start && !busy;
	assign width_a    = conv_pkg::addr_w'(image_width);
	assign small_img  = (image_width < 16'd3) || (image_height < 16'd3);
	assign col_last   = (col == image_width - 16'd1);
	assign row_last   = (row == image_height - 16'd3); // last output row
	assign own_cmd    = ((state == st_read_pix) || (state == st_write_res)) && !issued && !busy_req;

	// loader owns the requester during configuration
	always_comb begin
		if (state == st_config) begin
			cmd_valid = ld_cmd_valid;
			cmd_we    = 1'b0;
			cmd_addr  = ld_cmd_addr;
		end else begin
			cmd_valid = own_cmd;
			cmd_we    = (state == st_write_res);
			cmd_addr  = cmd_we ? res_addr : pix_addr;
		end
	end

	assign cmd_wdata  = {{(conv_pkg::mem_w - conv_pkg::pix_w){1'b0}}, res_byte};
	assign pix_valid  = (state == st_read_pix) && rsp_valid;
	assign pix_row    = pr;
	assign pix_data   = rsp_rdata[conv_pkg::pix_w-1:0];
	assign shift_cols = (state == st_shift);
	assign compute    = (state == st_compute);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			issued   <= 1'b0;
			row      <= '0;
			col      <= '0;
			pr       <= '0;
			row_base <= '0;
			col_base <= '0;
			pix_addr <= '0;
			res_addr <= '0;
		end else begin
			case (state)
				st_idle, st_finish: state <= load_start ? st_config : st_idle;
				st_config: begin
					if (load_done) begin
						if (small_img) begin
							state <= st_finish; // nothing to convolve
						end else begin
							row      <= '0;
							col      <= '0;
							pr       <= '0;
							row_base <= src_addr;
							col_base <= src_addr;
							pix_addr <= src_addr;
							res_addr <= dst_addr; // results are contiguous
							state    <= st_read_pix;
						end
					end
				end
				st_read_pix: begin
					if (own_cmd) issued <= 1'b1;
					if (rsp_valid && issued) begin
						issued   <= 1'b0;
						pr       <= pr + 2'd1;
						pix_addr <= pix_addr + width_a; // next row down
						if (pr == 2'd2) begin
							pr    <= '0;
							state <= st_shift;
						end
					end
				end
				st_shift: begin
					if (col < 16'd2) begin // window still filling
						col      <= col + 16'd1;
						col_base <= col_base + 32'd1;
						pix_addr <= col_base + 32'd1;
						state    <= st_read_pix;
					end else begin
						state <= st_compute;
					end
				end
				st_compute: state <= st_wait_res;
				st_wait_res: if (res_valid) state <= st_write_res;
				st_write_res: begin
					if (own_cmd) issued <= 1'b1;
					if (rsp_valid && issued) begin
						issued   <= 1'b0;
						res_addr <= res_addr + 32'd1;
						state    <= st_next;
					end
				end
				st_next: begin
					if (col_last) begin
						if (row_last) begin
							state <= st_finish;
						end else begin
							row      <= row + 16'd1;
							col      <= '0;
							row_base <= row_base + width_a;
							col_base <= row_base + width_a;
							pix_addr <= row_base + width_a;
							state    <= st_read_pix;
						end
					end else begin
						col      <= col + 16'd1;
						col_base <= col_base + 32'd1;
						pix_addr <= col_base + 32'd1;
						state    <= st_read_pix;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (res_valid) res_byte <= res_data;
	end

endmodule

// File: hw/conv_datapath.sv
module conv_datapath (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 pix_valid,
	input  logic [1:0]                           pix_row,
	input  logic [conv_pkg::pix_w-1:0]           pix_data,
	input  logic                                 shift_cols,
	input  logic                                 compute,
	input  logic signed [conv_pkg::tap_w-1:0]    tap0,
	input  logic signed [conv_pkg::tap_w-1:0]    tap1,
	input  logic signed [conv_pkg::tap_w-1:0]    tap2,
	input  logic signed [conv_pkg::tap_w-1:0]    tap3,
	input  logic signed [conv_pkg::tap_w-1:0]    tap4,
	input  logic signed [conv_pkg::tap_w-1:0]    tap5,
	input  logic signed [conv_pkg::tap_w-1:0]    tap6,
	input  logic signed [conv_pkg::tap_w-1:0]    tap7,
	input  logic signed [conv_pkg::tap_w-1:0]    tap8,
	output logic                                 res_valid,
	output logic [conv_pkg::pix_w-1:0]           res_data
);

	logic [conv_pkg::pix_w-1:0] stage [3];
	logic [conv_pkg::pix_w-1:0] win [conv_pkg::n_taps]; // row-major, column 0 oldest
	logic signed [conv_pkg::tap_w-1:0] taps [conv_pkg::n_taps];
	logic signed [conv_pkg::pix_w+conv_pkg::tap_w:0] prod [conv_pkg::n_taps];
	logic signed [conv_pkg::sum_w-1:0] sum;
	logic [conv_pkg::pipe_depth-1:0] vld;

	assign taps = '{tap0, tap1, tap2, tap3, tap4, tap5, tap6, tap7, tap8};

	always_ff @(posedge clk) begin
		if (pix_valid) stage[pix_row] <= pix_data;
		if (shift_cols) begin
			for (int r = 0; r < 3; r++) begin
				win[3*r]   <= win[3*r+1];
				win[3*r+1] <= win[3*r+2];
				win[3*r+2] <= stage[r];
			end
		end
		if (compute) begin // stage one
			for (int k = 0; k < conv_pkg::n_taps; k++) begin
				prod[k] <= $signed({1'b0, win[k]}) * taps[k];
			end
		end
	end

	always_comb begin
		sum = '0;
		for (int k = 0; k < conv_pkg::n_taps; k++) begin
			sum = sum + conv_pkg::sum_w'(prod[k]);
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) vld <= '0;
		else        vld <= {vld[conv_pkg::pipe_depth-2:0], compute};
	end

	assign res_valid = vld[conv_pkg::pipe_depth-1];

	// stage two, clamp to unsigned byte
	always_ff @(posedge clk) begin
		if (vld[0]) begin
			if (sum < 0)
				res_data <= '0;
			else if (sum > conv_pkg::sum_w'(conv_pkg::pix_max))
				res_data <= conv_pkg::pix_w'(conv_pkg::pix_max);
			else
				res_data <= sum[conv_pkg::pix_w-1:0];
		end
	end

endmodule

// File: hw/conv_accel_top.sv
module conv_accel_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           start,
	input  logic                           mem_ack,
	input  logic [conv_pkg::mem_w-1:0]     mem_rdata,
	output logic                           busy,
	output logic                           done,
	output logic                           mem_req,
	output logic                           mem_we,
	output logic [conv_pkg::addr_w-1:0]    mem_addr,
	output logic [conv_pkg::mem_w-1:0]     mem_wdata
);

	logic cmd_valid, cmd_we, busy_req, rsp_valid;
	logic [conv_pkg::addr_w-1:0] cmd_addr;
	logic [conv_pkg::mem_w-1:0]  cmd_wdata, rsp_rdata;
	logic pix_valid, shift_cols, compute, res_valid;
	logic [1:0] pix_row;
	logic [conv_pkg::pix_w-1:0] pix_data, res_data;
	logic signed [conv_pkg::tap_w-1:0] tap0, tap1, tap2, tap3, tap4;
	logic signed [conv_pkg::tap_w-1:0] tap5, tap6, tap7, tap8;

	conv_controller ctrl0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.busy_req   (busy_req),
		.rsp_valid  (rsp_valid),
		.rsp_rdata  (rsp_rdata),
		.res_valid  (res_valid),
		.res_data   (res_data),
		.busy       (busy),
		.done       (done),
		.cmd_valid  (cmd_valid),
		.cmd_we     (cmd_we),
		.cmd_addr   (cmd_addr),
		.cmd_wdata  (cmd_wdata),
		.pix_valid  (pix_valid),
		.pix_row    (pix_row),
		.pix_data   (pix_data),
		.shift_cols (shift_cols),
		.compute    (compute),
		.tap0(tap0), .tap1(tap1), .tap2(tap2), .tap3(tap3), .tap4(tap4),
		.tap5(tap5), .tap6(tap6), .tap7(tap7), .tap8(tap8)
	);

	mem_requester req0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_we    (cmd_we),
		.cmd_addr  (cmd_addr),
		.cmd_wdata (cmd_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.busy      (busy_req),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	conv_datapath dp0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.pix_valid  (pix_valid),
		.pix_row    (pix_row),
		.pix_data   (pix_data),
		.shift_cols (shift_cols),
		.compute    (compute),
		.tap0(tap0), .tap1(tap1), .tap2(tap2), .tap3(tap3), .tap4(tap4),
		.tap5(tap5), .tap6(tap6), .tap7(tap7), .tap8(tap8),
		.res_valid  (res_valid),
		.res_data   (res_data)
	);

endmodule

// File: dv/conv_accel_asserts.sv
module conv_accel_asserts (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        mem_req,
	input logic                        mem_ack,
	input logic                        mem_we,
	input logic [conv_pkg::addr_w-1:0] mem_addr,
	input logic [conv_pkg::mem_w-1:0]  mem_wdata,
	input logic                        done
);
	timeunit 1ns;
	timeprecision 100ps;

	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req)
		else $error("mem_req dropped before mem_ack");

	// request fields frozen during the handshake
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
		else $error("memory request fields changed while mem_req high");

	no_early_req: assert property (@(posedge clk) disable iff (!rst_n)
		!mem_req && mem_ack |=> !mem_req)
		else $error("mem_req raised while mem_ack still high");

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done longer than one cycle");

endmodule

// File: dv/tb_conv_accel.sv
module tb_conv_accel;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] src_base = 32'h0000_0100;
	localparam logic [31:0] dst_base = 32'h0000_0800;
	localparam int done_limit = 20000; // cycles

	logic clk, rst_n, start;
	logic mem_ack = 1'b0;
	logic [conv_pkg::mem_w-1:0] mem_rdata = '0;
	logic busy, done, mem_req, mem_we;
	logic [conv_pkg::addr_w-1:0] mem_addr;
	logic [conv_pkg::mem_w-1:0] mem_wdata;

	logic [31:0] mem [bit [31:0]];
	logic [31:0] lcg_state = 32'h0d58_d86f;
	bit slow_mem = 1'b0;
	int wait_cnt = 0;
	int access_cnt = 0;
	int write_cnt = 0;
	int stray_writes = 0;
	int done_cnt = 0;
	int res_words = 0;
	int img_w, img_h;
	logic [7:0] img [256];
	logic signed [7:0] taps [9];
	logic [7:0] expected [$];

	conv_accel_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.busy      (busy),
		.done      (done),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	bind conv_accel_top conv_accel_asserts asserts0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] mem_word(logic [31:0] a);
		if (mem.exists(a)) return mem[a];
		return {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3; // unwritten locations
	endfunction

	// four-phase slave, ack driven just after the edge
	always @(posedge clk) begin : responder
		logic [31:0] rd;
		if (rst_n && mem_ack && !mem_req) begin
			wait_cnt = slow_mem ? int'(next_rand() >> 20) % 4 : 0;
			#2 mem_ack = 1'b0;
		end else if (rst_n && mem_req && !mem_ack) begin
			if (wait_cnt > 0) begin
				wait_cnt = wait_cnt - 1;
			end else begin
				access_cnt++;
				if (mem_we) begin
					write_cnt++;
					if (mem_addr < dst_base || mem_addr >= dst_base + 32'(res_words))
						stray_writes++;
					mem[mem_addr] = mem_wdata;
				end
				rd = mem_word(mem_addr);
				#2;
				mem_rdata = rd;
				mem_ack = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (done) done_cnt++;
	end

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic check_eq(string test, int exp, int act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %0d, actual %0d", test, exp, act);
			$display("Simulation finished: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	task automatic load_image();
		mem.delete();
		mem[conv_pkg::config_addr + 32'(conv_pkg::cfg_width)]  = 32'(img_w);
		mem[conv_pkg::config_addr + 32'(conv_pkg::cfg_height)] = 32'(img_h);
		mem[conv_pkg::config_addr + 32'(conv_pkg::cfg_src)]    = src_base;
		mem[conv_pkg::config_addr + 32'(conv_pkg::cfg_dst)]    = dst_base;
		for (int k = 0; k < 9; k++) begin
			mem[conv_pkg::config_addr + 32'(conv_pkg::cfg_tap0 + k)] = 32'(taps[k]);
		end
		for (int i = 0; i < img_w * img_h; i++) begin
			mem[src_base + 32'(i)] = {24'h0, img[i]};
		end
		res_words = (img_w >= 3 && img_h >= 3) ? (img_w - 2) * (img_h - 2) : 0;
		write_cnt = 0;
		stray_writes = 0;
		access_cnt = 0;
		done_cnt = 0;
	endtask

	// valid 3x3 convolution, clamped to a byte
	task automatic ref_model();
		int acc;
		expected.delete();
		for (int oy = 0; oy < img_h - 2; oy++) begin
			for (int ox = 0; ox < img_w - 2; ox++) begin
				acc = 0;
				for (int ky = 0; ky < 3; ky++) begin
					for (int kx = 0; kx < 3; kx++) begin
						acc += int'(img[(oy + ky) * img_w + ox + kx]) * int'(taps[ky * 3 + kx]);
					end
				end
				expected.push_back(acc < 0 ? 8'd0 : (acc > 255 ? 8'd255 : 8'(acc)));
			end
		end
	endtask

	task automatic run_conv(string test);
		int cycles;
		cycles = 0;
		start = 1'b1;
		tick();
		start = 1'b0;
		while (!done) begin
			check_eq({test, " busy while running"}, 1, int'(busy));
			tick();
			cycles++;
			if (cycles > done_limit) begin
				$display("%s: no done pulse within %0d cycles", test, done_limit);
				$display("Simulation finished: FAIL");
				$fatal(1, "timeout");
			end
		end
		check_eq({test, " busy at done"}, 0, int'(busy));
		repeat (3) tick();
		check_eq({test, " done pulses"}, 1, done_cnt);
		check_eq({test, " busy after done"}, 0, int'(busy));
	endtask

	task automatic check_results(string test);
		check_eq({test, " writes"}, res_words, write_cnt);
		check_eq({test, " stray writes"}, 0, stray_writes);
		for (int i = 0; i < res_words; i++) begin
			check_eq($sformatf("%s word %0d", test, i), int'(expected[i]),
				int'(mem_word(dst_base + 32'(i))));
		end
	endtask

	task automatic random_image(int w, int h);
		img_w = w;
		img_h = h;
		for (int i = 0; i < w * h; i++) begin
			img[i] = next_rand() >> 16;
		end
	endtask

	task automatic test_reset();
		check_eq("test_reset mem_req", 0, int'(mem_req));
		check_eq("test_reset busy", 0, int'(busy));
		check_eq("test_reset done", 0, int'(done));
		repeat (10) tick();
		check_eq("test_reset accesses", 0, access_cnt);
	endtask

	task automatic test_identity();
		random_image(5, 4);
		foreach (taps[k]) taps[k] = 8'sd0;
		taps[4] = 8'sd1; // centre only
		load_image();
		expected.delete();
		for (int oy = 0; oy < 2; oy++) begin
			for (int ox = 0; ox < 3; ox++) begin
				expected.push_back(img[(oy + 1) * 5 + ox + 1]);
			end
		end
		run_conv("test_identity");
		check_results("test_identity");
	endtask

	task automatic test_saturation();
		img_w = 4;
		img_h = 4;
		for (int i = 0; i < 16; i++) img[i] = 8'd255;
		foreach (taps[k]) taps[k] = 8'sd127;
		load_image();
		expected = '{8'd255, 8'd255, 8'd255, 8'd255};
		run_conv("test_saturation high");
		check_results("test_saturation high");
		random_image(4, 4);
		foreach (taps[k]) taps[k] = -8'sd1;
		taps[4] = 8'sd0;
		load_image();
		expected = '{8'd0, 8'd0, 8'd0, 8'd0};
		run_conv("test_saturation low");
		check_results("test_saturation low");
	endtask

	task automatic test_random();
		random_image(8, 6);
		foreach (taps[k]) taps[k] = next_rand() >> 24;
		load_image();
		ref_model();
		run_conv("test_random");
		check_results("test_random");
	endtask

	// same image and taps as test_random
	task automatic test_slow_memory();
		slow_mem = 1'b1;
		load_image();
		ref_model();
		run_conv("test_slow_memory");
		check_results("test_slow_memory");
		slow_mem = 1'b0;
	endtask

	task automatic test_degenerate();
		random_image(2, 5);
		load_image();
		run_conv("test_degenerate");
		check_eq("test_degenerate writes", 0, write_cnt);
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
		test_reset();
		test_identity();
		test_saturation();
		test_random();
		test_slow_memory();
		test_degenerate();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: compile.f
hw/conv_pkg.sv
hw/mem_requester.sv
hw/conv_config_loader.sv
hw/conv_controller.sv
hw/conv_datapath.sv
hw/conv_accel_top.sv
dv/conv_accel_asserts.sv
dv/tb_conv_accel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the convolution testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_accel -f compile.f \
	-o sim_conv || { echo "build failed"; exit 1; }
./obj_dir/sim_conv > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log && echo "run passed" || { echo "run failed, see sim.log"; exit 1; }
